/* common/tlb_arch_pkg.sv */
package tlb_arch_pkg;

  // ========================================
  // address and tag widths
  // ========================================
  localparam int VALEN = 32;
  localparam int PALEN = 32;
  localparam int ASID_W = 10;

  // vppn covers va[31:13], one tag per even/odd page pair
  localparam int VPPN_W = VALEN - 13;

  // ========================================
  // page size
  // ========================================
  localparam int PS_W = 6;
  localparam logic [PS_W-1:0] PS_4K = 6'd12;
  // anything other than PS_4K is handled as a 4 MB page
  localparam logic [PS_W-1:0] PS_4M = 6'd21;

  // lowest vppn bit that takes part in a 4 MB compare (va bit 22)
  localparam int VPPN_4M_LSB = 22 - 13;

  localparam int PPN_W = PALEN - 12;

  // ========================================
  // lo word of one entry half
  // ========================================
  localparam int LO_V = 0;
  localparam int LO_D = 1;
  localparam int LO_PLV = 2;
  localparam int LO_PLV_W = 2;
  localparam int LO_MAT = 4;
  localparam int LO_MAT_W = 2;
  localparam int LO_PPN = 6;
  localparam int LO_W = LO_PPN + PPN_W;

  // vppn compare shared by search and invtlb
  // 4K pages compare the whole tag, 4M pages only va[31:22]
  function automatic logic vppn_hit(input logic [PS_W-1:0] ps,
                                    input logic [VPPN_W-1:0] ent_vppn,
                                    input logic [VPPN_W-1:0] req_vppn);
    if (ps == PS_4K) begin
      return ent_vppn == req_vppn;
    end
    return ent_vppn[VPPN_W-1:VPPN_4M_LSB] == req_vppn[VPPN_W-1:VPPN_4M_LSB];
  endfunction

endpackage

/* common/tlb_op_pkg.sv */
package tlb_op_pkg;

  // ========================================
  // invtlb operation codes
  // ========================================
  // codes 7 and above are illegal
  typedef enum logic [4:0] {
    // drop every entry
    INV_ALL0         = 5'd0,
    INV_ALL1         = 5'd1,
    // global entries only
    INV_GLO1         = 5'd2,
    // non-global entries only
    INV_GLO0         = 5'd3,
    // non-global with matching asid
    INV_GLO0_ASID    = 5'd4,
    // non-global, matching asid and va
    INV_GLO0_ASID_VA = 5'd5,
    // global or matching asid, and matching va
    INV_GLO1_ASID_VA = 5'd6
  } inv_op_e;

endpackage

/* run.sh */
#!/usr/bin/env bash
# build the tlb testbench with verilator and run it
# the exit status is the simulator's verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tlb_top.f --top-module tlb_tb -Mdir obj_dir \
  && ./obj_dir/Vtlb_tb \
  || { echo "build or simulation failed"; exit 1; }

/* tests/tlb_model.svh */
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

// ========================================
// reference entry array
// ========================================
logic              m_exist [ENTRY_NUM];
logic              m_glo   [ENTRY_NUM];
logic [ASID_W-1:0] m_asid  [ENTRY_NUM];
logic [PS_W-1:0]   m_ps    [ENTRY_NUM];
logic [VPPN_W-1:0] m_vppn  [ENTRY_NUM];
logic [LO_W-1:0]   m_lo0   [ENTRY_NUM];
logic [LO_W-1:0]   m_lo1   [ENTRY_NUM];

// 4K pages compare va[31:13], 4M pages only va[31:22] (vppn[18:9])
function automatic logic page_match(input logic [PS_W-1:0] ps,
                                    input logic [VPPN_W-1:0] a,
                                    input logic [VPPN_W-1:0] b);
  if (ps == 6'd12) begin
    return a == b;
  end
  return (a >> 9) == (b >> 9);
endfunction

// expected lookup, the last match in index order wins
function automatic void ref_search(input logic [ASID_W-1:0] asid,
                                   input logic [VALEN-1:12] va,
                                   output logic found,
                                   output logic [IDX_W-1:0] idx,
                                   output logic [PS_W-1:0] ps,
                                   output logic v,
                                   output logic d,
                                   output logic [LO_PLV_W-1:0] plv,
                                   output logic [LO_MAT_W-1:0] mat,
                                   output logic [PPN_W-1:0] ppn);
  logic            odd;
  logic [LO_W-1:0] lo;
  found = 1'b0;
  idx = '0;
  ps = '0;
  lo = '0;
  for (int i = 0; i < ENTRY_NUM; i++) begin
    if (m_exist[i] && (m_glo[i] || m_asid[i] == asid)
        && page_match(m_ps[i], m_vppn[i], va[31:13])) begin
      found = 1'b1;
      idx = IDX_W'(i);
      ps = m_ps[i];
      odd = (m_ps[i] == 6'd12) ? va[12] : va[21];
      lo = odd ? m_lo1[i] : m_lo0[i];
    end
  end
  v = lo[LO_V];
  d = lo[LO_D];
  plv = lo[LO_PLV +: LO_PLV_W];
  mat = lo[LO_MAT +: LO_MAT_W];
  ppn = lo[LO_PPN +: PPN_W];
endfunction

// invtlb rule for one entry
function automatic logic ref_kill(input inv_op_e op, input logic [ASID_W-1:0] asid,
                                  input logic [VPPN_W-1:0] vppn, input int i);
  logic a_hit;
  logic va_hit;
  a_hit = m_asid[i] == asid;
  va_hit = page_match(m_ps[i], m_vppn[i], vppn);
  case (op)
    INV_ALL0, INV_ALL1: return 1'b1;
    INV_GLO1:           return m_glo[i];
    INV_GLO0:           return !m_glo[i];
    INV_GLO0_ASID:      return !m_glo[i] && a_hit;
    INV_GLO0_ASID_VA:   return !m_glo[i] && a_hit && va_hit;
    INV_GLO1_ASID_VA:   return (m_glo[i] || a_hit) && va_hit;
    default:            return 1'b0;
  endcase
endfunction

task automatic model_clear();
  for (int i = 0; i < ENTRY_NUM; i++) begin
    m_exist[i] = 1'b0;
    m_glo[i] = 1'b0;
    m_asid[i] = '0;
    m_ps[i] = '0;
    m_vppn[i] = '0;
    m_lo0[i] = '0;
    m_lo1[i] = '0;
  end
endtask

// one edge, a write shadows a same-cycle invtlb
task automatic model_update();
  if (write_valid) begin
    m_exist[write_idx] = write_exist;
    m_glo[write_idx] = write_glo;
    m_asid[write_idx] = write_asid;
    m_ps[write_idx] = write_ps;
    m_vppn[write_idx] = write_vppn;
    m_lo0[write_idx] = write_lo0;
    m_lo1[write_idx] = write_lo1;
  end else if (inv_valid) begin
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (ref_kill(inv_op, inv_asid, inv_vppn, i)) begin
        m_exist[i] = 1'b0;
      end
    end
  end
endtask

`endif

/* tests/tlb_tb.sv */
module tlb_tb
  import tlb_arch_pkg::*;
  import tlb_op_pkg::*;
;

  localparam int ENTRY_NUM = 16;
  localparam int IDX_W = $clog2(ENTRY_NUM);

  // reset, empty check, fill, lookups, 7 invtlb rounds, random mix, tail
  localparam int TEST_CYCLES = 5 + 2 + 2 * ENTRY_NUM + 11
                             + 7 * (2 * ENTRY_NUM + 1) + 400 + 2;
  localparam int RUN_LIMIT = TEST_CYCLES * 20 + 400;

  localparam logic [VPPN_W-1:0] TAG_A = 19'h5a3c1;
  localparam logic [VPPN_W-1:0] TAG_B = 19'h12e07;
  localparam logic [VPPN_W-1:0] TAG_C = 19'h3b6d4;

  logic                clk;
  logic                rst_n;
  logic                search_valid;
  logic [ASID_W-1:0]   search_asid;
  logic [VALEN-1:12]   search_va;
  logic                search_found;
  logic [IDX_W-1:0]    search_idx;
  logic [PS_W-1:0]     search_ps;
  logic                search_v;
  logic                search_d;
  logic [LO_PLV_W-1:0] search_plv;
  logic [LO_MAT_W-1:0] search_mat;
  logic [PPN_W-1:0]    search_ppn;
  logic                read_valid;
  logic [IDX_W-1:0]    read_idx;
  logic                read_exist;
  logic                read_glo;
  logic [ASID_W-1:0]   read_asid;
  logic [PS_W-1:0]     read_ps;
  logic [VPPN_W-1:0]   read_vppn;
  logic [LO_W-1:0]     read_lo0;
  logic [LO_W-1:0]     read_lo1;
  logic                write_valid;
  logic [IDX_W-1:0]    write_idx;
  logic                write_exist;
  logic                write_glo;
  logic [ASID_W-1:0]   write_asid;
  logic [PS_W-1:0]     write_ps;
  logic [VPPN_W-1:0]   write_vppn;
  logic [LO_W-1:0]     write_lo0;
  logic [LO_W-1:0]     write_lo1;
  logic                inv_valid;
  inv_op_e             inv_op;
  logic [ASID_W-1:0]   inv_asid;
  logic [VPPN_W-1:0]   inv_vppn;

  // expected responses, filled at the sampling edge
  logic                search_due;
  logic                read_due;
  logic                exp_found;
  logic [IDX_W-1:0]    exp_sidx;
  logic [PS_W-1:0]     exp_sps;
  logic                exp_v;
  logic                exp_d;
  logic [LO_PLV_W-1:0] exp_plv;
  logic [LO_MAT_W-1:0] exp_mat;
  logic [PPN_W-1:0]    exp_ppn;
  logic [31:0]         lfsr;

  `include "tlb_model.svh"

  tlb_top #(.ENTRY_NUM(ENTRY_NUM)) UUT (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ========================================
  // random source
  // ========================================
  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // small tag space so random lookups actually hit
  function automatic logic [VPPN_W-1:0] pick_vppn();
    return {10'h2a5, 1'(rand_bits(1)), 5'b0, 3'(rand_bits(3))};
  endfunction

  function automatic inv_op_e pick_op();
    logic [2:0] r;
    r = 3'(rand_bits(3));
    if (r == 3'd7) begin
      return INV_GLO0;
    end
    return inv_op_e'({2'b00, r});
  endfunction

  // ========================================
  // checks
  // ========================================
  task automatic check_field(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
      $display("test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_search(input logic e_found, input logic [IDX_W-1:0] e_idx,
                              input logic [PS_W-1:0] e_ps, input logic e_v,
                              input logic e_d, input logic [LO_PLV_W-1:0] e_plv,
                              input logic [LO_MAT_W-1:0] e_mat,
                              input logic [PPN_W-1:0] e_ppn);
    check_field("search_found", 64'(e_found), 64'(search_found));
    check_field("search_idx", 64'(e_idx), 64'(search_idx));
    check_field("search_ps", 64'(e_ps), 64'(search_ps));
    check_field("search_v", 64'(e_v), 64'(search_v));
    check_field("search_d", 64'(e_d), 64'(search_d));
    check_field("search_plv", 64'(e_plv), 64'(search_plv));
    check_field("search_mat", 64'(e_mat), 64'(search_mat));
    check_field("search_ppn", 64'(e_ppn), 64'(search_ppn));
  endtask

  task automatic check_read(input logic e_exist, input logic e_glo,
                            input logic [ASID_W-1:0] e_asid, input logic [PS_W-1:0] e_ps,
                            input logic [VPPN_W-1:0] e_vppn, input logic [LO_W-1:0] e_lo0,
                            input logic [LO_W-1:0] e_lo1);
    check_field("read_exist", 64'(e_exist), 64'(read_exist));
    check_field("read_glo", 64'(e_glo), 64'(read_glo));
    check_field("read_asid", 64'(e_asid), 64'(read_asid));
    check_field("read_ps", 64'(e_ps), 64'(read_ps));
    check_field("read_vppn", 64'(e_vppn), 64'(read_vppn));
    check_field("read_lo0", 64'(e_lo0), 64'(read_lo0));
    check_field("read_lo1", 64'(e_lo1), 64'(read_lo1));
  endtask

  // read expectation is the model entry as it was before the edge
  logic              exp_exist;
  logic              exp_glo;
  logic [ASID_W-1:0] exp_asid;
  logic [PS_W-1:0]   exp_ps;
  logic [VPPN_W-1:0] exp_vppn;
  logic [LO_W-1:0]   exp_lo0;
  logic [LO_W-1:0]   exp_lo1;

  always @(posedge clk) begin
    if (!rst_n) begin
      model_clear();
      search_due = 1'b0;
      read_due = 1'b0;
    end else begin
      search_due = search_valid;
      read_due = read_valid;
      if (search_valid) begin
        ref_search(search_asid, search_va, exp_found, exp_sidx, exp_sps, exp_v, exp_d,
                   exp_plv, exp_mat, exp_ppn);
      end
      if (read_valid) begin
        exp_exist = m_exist[read_idx];
        exp_glo = m_glo[read_idx];
        exp_asid = m_asid[read_idx];
        exp_ps = m_ps[read_idx];
        exp_vppn = m_vppn[read_idx];
        exp_lo0 = m_lo0[read_idx];
        exp_lo1 = m_lo1[read_idx];
      end
      model_update();
    end
  end

  // responses are settled by the falling edge
  always @(negedge clk) begin
    if (search_due) begin
      check_search(exp_found, exp_sidx, exp_sps, exp_v, exp_d, exp_plv, exp_mat, exp_ppn);
    end
    if (read_due) begin
      check_read(exp_exist, exp_glo, exp_asid, exp_ps, exp_vppn, exp_lo0, exp_lo1);
    end
  end

  initial begin
    #(RUN_LIMIT);
    $display("timeout: the run did not finish within %0d time units", RUN_LIMIT);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  // ========================================
  // stimulus
  // ========================================
  task automatic tick();
    @(posedge clk);
    #2;
    search_valid = 1'b0;
    read_valid = 1'b0;
    write_valid = 1'b0;
    inv_valid = 1'b0;
  endtask

  task automatic set_search(input logic [ASID_W-1:0] asid, input logic [VALEN-1:12] va);
    search_valid = 1'b1;
    search_asid = asid;
    search_va = va;
  endtask

  task automatic set_read(input logic [IDX_W-1:0] idx);
    read_valid = 1'b1;
    read_idx = idx;
  endtask

  task automatic set_write(input logic [IDX_W-1:0] idx, input logic exist, input logic glo,
                           input logic [ASID_W-1:0] asid, input logic [PS_W-1:0] ps,
                           input logic [VPPN_W-1:0] vppn, input logic [LO_W-1:0] lo0,
                           input logic [LO_W-1:0] lo1);
    write_valid = 1'b1;
    write_idx = idx;
    write_exist = exist;
    write_glo = glo;
    write_asid = asid;
    write_ps = ps;
    write_vppn = vppn;
    write_lo0 = lo0;
    write_lo1 = lo1;
  endtask

  task automatic set_write_random(input logic [IDX_W-1:0] idx,
                                  input logic [ASID_W-1:0] asid,
                                  input logic [VPPN_W-1:0] vppn);
    set_write(idx, 1'(rand_bits(1)), 1'(rand_bits(1)), asid,
              (rand_bits(1) != 0) ? 6'd21 : 6'd12, vppn,
              LO_W'(rand_bits(LO_W)), LO_W'(rand_bits(LO_W)));
  endtask

  task automatic set_inv(input inv_op_e op, input logic [ASID_W-1:0] asid,
                         input logic [VPPN_W-1:0] vppn);
    inv_valid = 1'b1;
    inv_op = op;
    inv_asid = asid;
    inv_vppn = vppn;
  endtask

  initial begin
    lfsr = 32'hd6ebbe7d;
    rst_n = 1'b0;
    search_valid = 1'b0;
    search_asid = '0;
    search_va = '0;
    read_valid = 1'b0;
    read_idx = '0;
    write_valid = 1'b0;
    write_idx = '0;
    write_exist = 1'b0;
    write_glo = 1'b0;
    write_asid = '0;
    write_ps = '0;
    write_vppn = '0;
    write_lo0 = '0;
    write_lo1 = '0;
    inv_valid = 1'b0;
    inv_op = INV_ALL0;
    inv_asid = '0;
    inv_vppn = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // outputs start cleared, empty tlb misses
    check_search(1'b0, '0, '0, 1'b0, 1'b0, '0, '0, '0);
    check_read(1'b0, 1'b0, '0, '0, '0, '0, '0);
    set_search(ASID_W'(rand_bits(ASID_W)), 20'(rand_bits(20)));
    tick();
    tick();

    // fill every index, then read it back
    for (int i = 0; i < ENTRY_NUM; i++) begin
      set_write_random(IDX_W'(i), ASID_W'(rand_bits(ASID_W)), VPPN_W'(rand_bits(VPPN_W)));
      tick();
    end
    for (int i = 0; i < ENTRY_NUM; i++) begin
      set_read(IDX_W'(i));
      tick();
    end

    // directed lookups on a clean array
    set_inv(INV_ALL0, '0, '0);
    tick();
    set_write(IDX_W'(2), 1'b1, 1'b0, 10'd5, 6'd12, TAG_A,
              LO_W'(rand_bits(LO_W)), LO_W'(rand_bits(LO_W)));
    tick();
    set_write(IDX_W'(3), 1'b1, 1'b1, 10'd7, 6'd21, TAG_B,
              LO_W'(rand_bits(LO_W)), LO_W'(rand_bits(LO_W)));
    tick();
    // duplicate tag at a higher index
    set_write(IDX_W'(9), 1'b1, 1'b0, 10'd5, 6'd12, TAG_A,
              LO_W'(rand_bits(LO_W)), LO_W'(rand_bits(LO_W)));
    tick();
    set_search(10'd5, {TAG_A, 1'b0});
    tick();
    set_search(10'd5, {TAG_A, 1'b1});
    tick();
    // wrong asid, not global
    set_search(10'd6, {TAG_A, 1'b0});
    tick();
    // global 4M entry, odd half picked by va[21]
    set_search(10'd1, {TAG_B & ~19'h00100, 1'b1});
    tick();
    set_search(10'd1, {TAG_B | 19'h00100, 1'b0});
    tick();
    set_write(IDX_W'(9), 1'b0, 1'b0, 10'd5, 6'd12, TAG_A, '0, '0);
    tick();
    set_search(10'd5, {TAG_A, 1'b1});
    tick();

    // each invtlb op on a known mix of entries
    for (int op = 0; op < 7; op++) begin
      for (int i = 0; i < ENTRY_NUM; i++) begin
        set_write(IDX_W'(i), 1'b1, i[0], i[2] ? 10'd5 : 10'd6, i[1] ? 6'd21 : 6'd12,
                  i[3] ? TAG_C : TAG_C ^ 19'h00100,
                  LO_W'(rand_bits(LO_W)), LO_W'(rand_bits(LO_W)));
        tick();
      end
      set_inv(inv_op_e'(5'(op)), 10'd5, TAG_C);
      tick();
      for (int i = 0; i < ENTRY_NUM; i++) begin
        set_read(IDX_W'(i));
        tick();
      end
    end

    // random mix, write and invtlb may collide
    repeat (400) begin
      if (rand_bits(1) != 0) begin
        set_search(ASID_W'(rand_bits(2)), {pick_vppn(), 1'(rand_bits(1))});
      end
      if (rand_bits(1) != 0) begin
        set_read(IDX_W'(rand_bits(IDX_W)));
      end
      if (rand_bits(1) != 0) begin
        set_write_random(IDX_W'(rand_bits(IDX_W)), ASID_W'(rand_bits(2)), pick_vppn());
      end
      if (rand_bits(1) != 0) begin
        set_inv(pick_op(), ASID_W'(rand_bits(2)), pick_vppn());
      end
      tick();
    end

    tick();
    @(negedge clk);
    #1;
    $display("test passed");
    $finish;
  end

endmodule

/* tlb/tlb_entry_file.sv */
module tlb_entry_file
  import tlb_arch_pkg::*;
#(
  parameter int ENTRY_NUM = 16,
  localparam int IDX_W = $clog2(ENTRY_NUM)
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // write port (tlbwr / tlbfill)
  input  logic                               write_valid,
  input  logic [IDX_W-1:0]                   write_idx,
  input  logic                               write_exist,
  input  logic                               write_glo,
  input  logic [ASID_W-1:0]                  write_asid,
  input  logic [PS_W-1:0]                    write_ps,
  input  logic [VPPN_W-1:0]                  write_vppn,
  input  logic [LO_W-1:0]                    write_lo0,
  input  logic [LO_W-1:0]                    write_lo1,
  // exist clear from the invalidate unit
  input  logic [ENTRY_NUM-1:0]               kill_mask,
  // read port (tlbrd)
  input  logic                               read_valid,
  input  logic [IDX_W-1:0]                   read_idx,
  output logic                               read_exist,
  output logic                               read_glo,
  output logic [ASID_W-1:0]                  read_asid,
  output logic [PS_W-1:0]                    read_ps,
  output logic [VPPN_W-1:0]                  read_vppn,
  output logic [LO_W-1:0]                    read_lo0,
  output logic [LO_W-1:0]                    read_lo1,
  // stored entries, one slice per entry
  output logic [ENTRY_NUM-1:0]               ent_exist,
  output logic [ENTRY_NUM-1:0]               ent_glo,
  output logic [ENTRY_NUM-1:0][ASID_W-1:0]   ent_asid,
  output logic [ENTRY_NUM-1:0][PS_W-1:0]     ent_ps,
  output logic [ENTRY_NUM-1:0][VPPN_W-1:0]   ent_vppn,
  output logic [ENTRY_NUM-1:0][LO_W-1:0]     ent_lo0,
  output logic [ENTRY_NUM-1:0][LO_W-1:0]     ent_lo1
);

  // ========================================
  // entry array
  // ========================================
  // a write replaces the whole entry, invtlb only touches exist
  // and loses to a write in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_exist <= '0;
      ent_glo   <= '0;
      ent_asid  <= '0;
      ent_ps    <= '0;
      ent_vppn  <= '0;
      ent_lo0   <= '0;
      ent_lo1   <= '0;
    end else if (write_valid) begin
      ent_exist[write_idx] <= write_exist;
      ent_glo[write_idx]   <= write_glo;
      ent_asid[write_idx]  <= write_asid;
      ent_ps[write_idx]    <= write_ps;
      ent_vppn[write_idx]  <= write_vppn;
      ent_lo0[write_idx]   <= write_lo0;
      ent_lo1[write_idx]   <= write_lo1;
    end else begin
      // mask is already zero when no invtlb is pending
      ent_exist <= ent_exist & ~kill_mask;
    end
  end

  // ========================================
  // read port
  // ========================================
  // registered copy, sees the array before this edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_exist <= 1'b0;
      read_glo   <= 1'b0;
      read_asid  <= '0;
      read_ps    <= '0;
      read_vppn  <= '0;
      read_lo0   <= '0;
      read_lo1   <= '0;
    end else if (read_valid) begin
      read_exist <= ent_exist[read_idx];
      read_glo   <= ent_glo[read_idx];
      read_asid  <= ent_asid[read_idx];
      read_ps    <= ent_ps[read_idx];
      read_vppn  <= ent_vppn[read_idx];
      read_lo0   <= ent_lo0[read_idx];
      read_lo1   <= ent_lo1[read_idx];
    end
  end

  // ========================================
  // checks
  // ========================================
  a_write_idx_range : assert property (
    @(posedge clk) disable iff (!rst_n)
      write_valid |-> int'(write_idx) < ENTRY_NUM
  ) else $error("tlb_entry_file: write_idx %0d out of range", write_idx);

  a_read_idx_range : assert property (
    @(posedge clk) disable iff (!rst_n)
      read_valid |-> int'(read_idx) < ENTRY_NUM
  ) else $error("tlb_entry_file: read_idx %0d out of range", read_idx);

endmodule

/* tlb/tlb_inv_unit.sv */
module tlb_inv_unit
  import tlb_arch_pkg::*;
  import tlb_op_pkg::*;
#(
  parameter int ENTRY_NUM = 16
) (
  // invtlb request
  input  logic                               inv_valid,
  input  inv_op_e                            inv_op,
  input  logic [ASID_W-1:0]                  inv_asid,
  input  logic [VPPN_W-1:0]                  inv_vppn,
  // stored entries
  input  logic [ENTRY_NUM-1:0]               ent_exist,
  input  logic [ENTRY_NUM-1:0]               ent_glo,
  input  logic [ENTRY_NUM-1:0][ASID_W-1:0]   ent_asid,
  input  logic [ENTRY_NUM-1:0][PS_W-1:0]     ent_ps,
  input  logic [ENTRY_NUM-1:0][VPPN_W-1:0]   ent_vppn,
  // exist clear towards the entry file
  output logic [ENTRY_NUM-1:0]               kill_mask
);

  logic [ENTRY_NUM-1:0] asid_hit;
  logic [ENTRY_NUM-1:0] va_hit;
  logic [ENTRY_NUM-1:0] sel;

  // ========================================
  // per-entry conditions
  // ========================================
  for (genvar i = 0; i < ENTRY_NUM; i++) begin : g_cond
    assign asid_hit[i] = ent_asid[i] == inv_asid;
    // 4M entries ignore the low vppn bits
    assign va_hit[i]   = vppn_hit(ent_ps[i], ent_vppn[i], inv_vppn);
  end

  // ========================================
  // op decode
  // ========================================
  always_comb begin
    case (inv_op)
      INV_ALL0, INV_ALL1: sel = '1;
      INV_GLO1:           sel = ent_glo;
      INV_GLO0:           sel = ~ent_glo;
      INV_GLO0_ASID:      sel = ~ent_glo & asid_hit;
      INV_GLO0_ASID_VA:   sel = ~ent_glo & asid_hit & va_hit;
      INV_GLO1_ASID_VA:   sel = (ent_glo | asid_hit) & va_hit;
      // unknown op clears nothing
      default:            sel = '0;
    endcase
  end

  assign kill_mask = inv_valid ? (sel & ent_exist) : '0;

  // ========================================
  // checks
  // ========================================
  // codes above INV_GLO1_ASID_VA are not defined
  always_comb begin
    if (inv_valid) begin
      a_inv_op_legal : assert (inv_op <= INV_GLO1_ASID_VA)
        else $error("tlb_inv_unit: illegal invtlb op %0d", inv_op);
    end
  end

endmodule

/* tlb/tlb_search_unit.sv */
module tlb_search_unit
  import tlb_arch_pkg::*;
#(
  parameter int ENTRY_NUM = 16,
  localparam int IDX_W = $clog2(ENTRY_NUM)
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // lookup request
  input  logic                               search_valid,
  input  logic [ASID_W-1:0]                  search_asid,
  input  logic [VALEN-1:12]                  search_va,
  // stored entries
  input  logic [ENTRY_NUM-1:0]               ent_exist,
  input  logic [ENTRY_NUM-1:0]               ent_glo,
  input  logic [ENTRY_NUM-1:0][ASID_W-1:0]   ent_asid,
  input  logic [ENTRY_NUM-1:0][PS_W-1:0]     ent_ps,
  input  logic [ENTRY_NUM-1:0][VPPN_W-1:0]   ent_vppn,
  input  logic [ENTRY_NUM-1:0][LO_W-1:0]     ent_lo0,
  input  logic [ENTRY_NUM-1:0][LO_W-1:0]     ent_lo1,
  // registered response
  output logic                               search_found,
  output logic [IDX_W-1:0]                   search_idx,
  output logic [PS_W-1:0]                    search_ps,
  output logic                               search_v,
  output logic                               search_d,
  output logic [LO_PLV_W-1:0]                search_plv,
  output logic [LO_MAT_W-1:0]                search_mat,
  output logic [PPN_W-1:0]                   search_ppn
);

  logic [ENTRY_NUM-1:0] match;

  logic                 hit_any;
  logic [IDX_W-1:0]     hit_idx;
  logic [PS_W-1:0]      hit_ps;
  logic [LO_W-1:0]      hit_lo0;
  logic [LO_W-1:0]      hit_lo1;
  logic                 hit_odd;
  logic [LO_W-1:0]      hit_lo;

  // ========================================
  // per-entry compare
  // ========================================
  for (genvar i = 0; i < ENTRY_NUM; i++) begin : g_match
    assign match[i] = ent_exist[i]
                    && (ent_glo[i] || (ent_asid[i] == search_asid))
                    && vppn_hit(ent_ps[i], ent_vppn[i], search_va[VALEN-1:13]);
  end

  // highest matching index wins
  // everything stays zero on a miss
  always_comb begin
    hit_any = 1'b0;
    hit_idx = '0;
    hit_ps  = '0;
    hit_lo0 = '0;
    hit_lo1 = '0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (match[i]) begin
        hit_any = 1'b1;
        hit_idx = IDX_W'(i);
        hit_ps  = ent_ps[i];
        hit_lo0 = ent_lo0[i];
        hit_lo1 = ent_lo1[i];
      end
    end
  end

  // odd page is picked by the first va bit above the page offset
  assign hit_odd = (hit_ps == PS_4K) ? search_va[PS_4K] : search_va[PS_4M];
  assign hit_lo  = hit_odd ? hit_lo1 : hit_lo0;

  // ========================================
  // response registers
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      search_found <= 1'b0;
      search_idx   <= '0;
      search_ps    <= '0;
      search_v     <= 1'b0;
      search_d     <= 1'b0;
      search_plv   <= '0;
      search_mat   <= '0;
      search_ppn   <= '0;
    end else if (search_valid) begin
      search_found <= hit_any;
      search_idx   <= hit_idx;
      search_ps    <= hit_ps;
      search_v     <= hit_lo[LO_V];
      search_d     <= hit_lo[LO_D];
      search_plv   <= hit_lo[LO_PLV +: LO_PLV_W];
      search_mat   <= hit_lo[LO_MAT +: LO_MAT_W];
      search_ppn   <= hit_lo[LO_PPN +: PPN_W];
    end
  end

  // ========================================
  // checks
  // ========================================
  // response only moves after a request
  a_found_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
      !$past(search_valid) |-> $stable(search_found)
  ) else $error("tlb_search_unit: search_found changed without a search");

endmodule

/* tlb_top.f */
+incdir+tests
common/tlb_arch_pkg.sv
common/tlb_op_pkg.sv
tlb/tlb_entry_file.sv
tlb/tlb_search_unit.sv
tlb/tlb_inv_unit.sv
verilog/tlb_top.sv
tests/tlb_tb.sv

/* verilog/tlb_top.sv */
module tlb_top
  import tlb_arch_pkg::*;
  import tlb_op_pkg::*;
#(
  parameter int ENTRY_NUM = 16,
  localparam int IDX_W = $clog2(ENTRY_NUM)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // search
  input  logic                  search_valid,
  input  logic [ASID_W-1:0]     search_asid,
  input  logic [VALEN-1:12]     search_va,
  output logic                  search_found,
  output logic [IDX_W-1:0]      search_idx,
  output logic [PS_W-1:0]       search_ps,
  output logic                  search_v,
  output logic                  search_d,
  output logic [LO_PLV_W-1:0]   search_plv,
  output logic [LO_MAT_W-1:0]   search_mat,
  output logic [PPN_W-1:0]      search_ppn,
  // tlbrd
  input  logic                  read_valid,
  input  logic [IDX_W-1:0]      read_idx,
  output logic                  read_exist,
  output logic                  read_glo,
  output logic [ASID_W-1:0]     read_asid,
  output logic [PS_W-1:0]       read_ps,
  output logic [VPPN_W-1:0]     read_vppn,
  output logic [LO_W-1:0]       read_lo0,
  output logic [LO_W-1:0]       read_lo1,
  // tlbwr / tlbfill
  input  logic                  write_valid,
  input  logic [IDX_W-1:0]      write_idx,
  input  logic                  write_exist,
  input  logic                  write_glo,
  input  logic [ASID_W-1:0]     write_asid,
  input  logic [PS_W-1:0]       write_ps,
  input  logic [VPPN_W-1:0]     write_vppn,
  input  logic [LO_W-1:0]       write_lo0,
  input  logic [LO_W-1:0]       write_lo1,
  // invtlb
  input  logic                  inv_valid,
  input  inv_op_e               inv_op,
  input  logic [ASID_W-1:0]     inv_asid,
  input  logic [VPPN_W-1:0]     inv_vppn
);

  // stored entries, shared by search and invalidate
  logic [ENTRY_NUM-1:0]               ent_exist;
  logic [ENTRY_NUM-1:0]               ent_glo;
  logic [ENTRY_NUM-1:0][ASID_W-1:0]   ent_asid;
  logic [ENTRY_NUM-1:0][PS_W-1:0]     ent_ps;
  logic [ENTRY_NUM-1:0][VPPN_W-1:0]   ent_vppn;
  logic [ENTRY_NUM-1:0][LO_W-1:0]     ent_lo0;
  logic [ENTRY_NUM-1:0][LO_W-1:0]     ent_lo1;
  logic [ENTRY_NUM-1:0]               kill_mask;

  // ========================================
  // storage
  // ========================================
  tlb_entry_file #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_entry_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .write_valid (write_valid),
    .write_idx   (write_idx),
    .write_exist (write_exist),
    .write_glo   (write_glo),
    .write_asid  (write_asid),
    .write_ps    (write_ps),
    .write_vppn  (write_vppn),
    .write_lo0   (write_lo0),
    .write_lo1   (write_lo1),
    .kill_mask   (kill_mask),
    .read_valid  (read_valid),
    .read_idx    (read_idx),
    .read_exist  (read_exist),
    .read_glo    (read_glo),
    .read_asid   (read_asid),
    .read_ps     (read_ps),
    .read_vppn   (read_vppn),
    .read_lo0    (read_lo0),
    .read_lo1    (read_lo1),
    .ent_exist   (ent_exist),
    .ent_glo     (ent_glo),
    .ent_asid    (ent_asid),
    .ent_ps      (ent_ps),
    .ent_vppn    (ent_vppn),
    .ent_lo0     (ent_lo0),
    .ent_lo1     (ent_lo1)
  );

  // ========================================
  // lookup
  // ========================================
  tlb_search_unit #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_search_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .search_valid (search_valid),
    .search_asid  (search_asid),
    .search_va    (search_va),
    .ent_exist    (ent_exist),
    .ent_glo      (ent_glo),
    .ent_asid     (ent_asid),
    .ent_ps       (ent_ps),
    .ent_vppn     (ent_vppn),
    .ent_lo0      (ent_lo0),
    .ent_lo1      (ent_lo1),
    .search_found (search_found),
    .search_idx   (search_idx),
    .search_ps    (search_ps),
    .search_v     (search_v),
    .search_d     (search_d),
    .search_plv   (search_plv),
    .search_mat   (search_mat),
    .search_ppn   (search_ppn)
  );

  // ========================================
  // invtlb
  // ========================================
  tlb_inv_unit #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_inv_unit (
    .inv_valid (inv_valid),
    .inv_op    (inv_op),
    .inv_asid  (inv_asid),
    .inv_vppn  (inv_vppn),
    .ent_exist (ent_exist),
    .ent_glo   (ent_glo),
    .ent_asid  (ent_asid),
    .ent_ps    (ent_ps),
    .ent_vppn  (ent_vppn),
    .kill_mask (kill_mask)
  );

endmodule
